// File: common/csr_pkg.sv
package csr_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int ZIMM_W     = 5;

  // ----------------------------------------------------------------------
  // machine-mode CSR addresses
  // ----------------------------------------------------------------------
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MISA     = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL    = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIP      = 12'h344;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE   = 12'hB00;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH  = 12'hB80;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1, // csrrw / csrrwi
    CSR_RS   = 2'd2, // csrrs / csrrsi
    CSR_RC   = 2'd3  // csrrc / csrrci
  } csr_op_e;

  typedef enum logic [2:0] {
    EXCP_NONE    = 3'd0,
    EXCP_ILLEGAL = 3'd1,
    EXCP_ECALL_U = 3'd2,
    EXCP_BREAK   = 3'd3,
    EXCP_MRET    = 3'd4  // not a trap, return path
  } excp_e;

  // mcause exception codes, interrupt bit kept separately
  localparam logic [XLEN-2:0] CAUSE_ILLEGAL = 31'd2;
  localparam logic [XLEN-2:0] CAUSE_BREAK   = 31'd3;
  localparam logic [XLEN-2:0] CAUSE_ECALL_U = 31'd8;

  localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100; // direct mode
  localparam logic [XLEN-1:0] MISA_VALUE  = 32'h4000_0100; // rv32, i
  localparam logic [1:0]      MPP_MACHINE = 2'b11;
  localparam logic [XLEN-1:0] MIE_MASK    = 32'h0000_0888; // meie, mtie, msie

  // new register value for csrrw / csrrs / csrrc
  function automatic logic [XLEN-1:0] csr_apply(input logic [XLEN-1:0] old_val,
                                                input csr_op_e         op,
                                                input logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] new_val;
    new_val = old_val;
    case (op)
      CSR_RW:  new_val = wdata;
      CSR_RS:  new_val = old_val | wdata;
      CSR_RC:  new_val = old_val & ~wdata;
      default: new_val = old_val;
    endcase
    return new_val;
  endfunction

endpackage

// File: rtl/csr_write_ctrl.sv
`timescale 1ns/1ps

module csr_write_ctrl (
  input  logic [csr_pkg::XLEN-1:0]       rs1_i,
  input  logic [csr_pkg::ZIMM_W-1:0]     zimm_i,
  input  logic                           use_zimm_i,
  input  csr_pkg::csr_op_e               csr_op_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::excp_e                 excp_i,
  output logic [csr_pkg::XLEN-1:0]       wdata_o,
  output csr_pkg::csr_op_e               op_o,
  output logic                           wr_mtvec_o,
  output logic                           wr_mie_o,
  output logic                           wr_mscratch_o,
  output logic                           wr_mepc_o,
  output logic                           wr_mtval_o,
  output logic                           wr_cycle_lo_o,
  output logic                           wr_cycle_hi_o
);

  logic [csr_pkg::XLEN-1:0] zimm_ext;
  logic                     wr_en;

  // ----------------------------------------------------------------------
  // operand select
  // ----------------------------------------------------------------------
  assign zimm_ext = {{(csr_pkg::XLEN-csr_pkg::ZIMM_W){1'b0}}, zimm_i}; // zero-extended uimm
  assign wdata_o  = use_zimm_i ? zimm_ext : rs1_i;
  assign op_o     = csr_op_i;

  // no csr write retires alongside a trap or mret
  assign wr_en = (csr_op_i != csr_pkg::CSR_NONE) && (excp_i == csr_pkg::EXCP_NONE);

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  assign wr_mtvec_o    = wr_en && (csr_addr_i == csr_pkg::ADDR_MTVEC);
  assign wr_mie_o      = wr_en && (csr_addr_i == csr_pkg::ADDR_MIE);
  assign wr_mscratch_o = wr_en && (csr_addr_i == csr_pkg::ADDR_MSCRATCH);
  assign wr_mepc_o     = wr_en && (csr_addr_i == csr_pkg::ADDR_MEPC);
  assign wr_mtval_o    = wr_en && (csr_addr_i == csr_pkg::ADDR_MTVAL);
  assign wr_cycle_lo_o = wr_en && (csr_addr_i == csr_pkg::ADDR_MCYCLE);
  assign wr_cycle_hi_o = wr_en && (csr_addr_i == csr_pkg::ADDR_MCYCLEH);

  // mstatus, misa, mcause and mip have no strobe, writes drop silently

endmodule

// File: rtl/csr_trap_unit.sv
`timescale 1ns/1ps

module csr_trap_unit (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [csr_pkg::XLEN-1:0] pc_i,
  input  logic [csr_pkg::XLEN-1:0] inst_i,
  input  csr_pkg::excp_e           excp_i,
  input  logic [csr_pkg::XLEN-1:0] wdata_i,
  input  csr_pkg::csr_op_e         op_i,
  input  logic                     wr_mepc_i,
  input  logic                     wr_mtval_i,
  input  logic [csr_pkg::XLEN-1:0] mtvec_i,
  output logic [csr_pkg::XLEN-1:0] mepc_o,
  output logic [csr_pkg::XLEN-1:0] mcause_o,
  output logic [csr_pkg::XLEN-1:0] mtval_o,
  output logic                     mstatus_mie_o,
  output logic                     mstatus_mpie_o,
  output logic                     trap_tkn_o,
  output logic [csr_pkg::XLEN-1:0] trap_vec_o,
  output logic                     mret_tkn_o,
  output logic [csr_pkg::XLEN-1:0] mret_pc_o
);

  logic [csr_pkg::XLEN-1:0] mepc_q, mcause_q, mtval_q;
  logic                     mie_q, mpie_q;
  logic [csr_pkg::XLEN-2:0] trap_cause;

  // ----------------------------------------------------------------------
  // event decode
  // ----------------------------------------------------------------------
  always_comb begin
    trap_tkn_o = 1'b0;
    trap_cause = '0;
    case (excp_i)
      csr_pkg::EXCP_ILLEGAL: begin
        trap_tkn_o = 1'b1;
        trap_cause = csr_pkg::CAUSE_ILLEGAL;
      end
      csr_pkg::EXCP_ECALL_U: begin
        trap_tkn_o = 1'b1;
        trap_cause = csr_pkg::CAUSE_ECALL_U;
      end
      csr_pkg::EXCP_BREAK: begin
        trap_tkn_o = 1'b1;
        trap_cause = csr_pkg::CAUSE_BREAK;
      end
      default: ;
    endcase
  end

  assign mret_tkn_o = (excp_i == csr_pkg::EXCP_MRET);
  assign trap_vec_o = mtvec_i;  // direct mode only
  assign mret_pc_o  = mepc_q;

  // ----------------------------------------------------------------------
  // trap state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
      mie_q    <= 1'b0; // interrupts off
      mpie_q   <= 1'b1;
    end else if (trap_tkn_o) begin
      mepc_q   <= pc_i;
      mcause_q <= {1'b0, trap_cause}; // synchronous exception
      if (excp_i == csr_pkg::EXCP_ILLEGAL) begin
        mtval_q <= inst_i; // faulting instruction word
      end
    end else if (mret_tkn_o) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
    end else begin
      if (wr_mepc_i) begin
        mepc_q <= csr_pkg::csr_apply(mepc_q, op_i, wdata_i);
      end
      if (wr_mtval_i) begin
        mtval_q <= csr_pkg::csr_apply(mtval_q, op_i, wdata_i);
      end
    end
  end

  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign mtval_o        = mtval_q;
  assign mstatus_mie_o  = mie_q;
  assign mstatus_mpie_o = mpie_q;

endmodule

// File: rtl/csr_setup_regs.sv
`timescale 1ns/1ps

module csr_setup_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [csr_pkg::XLEN-1:0] wdata_i,
  input  csr_pkg::csr_op_e         op_i,
  input  logic                     wr_mtvec_i,
  input  logic                     wr_mie_i,
  input  logic                     wr_mscratch_i,
  output logic [csr_pkg::XLEN-1:0] mtvec_o,
  output logic [csr_pkg::XLEN-1:0] mie_o,
  output logic [csr_pkg::XLEN-1:0] mscratch_o
);

  logic [csr_pkg::XLEN-1:0] mtvec_q;
  logic [csr_pkg::XLEN-1:0] mie_q;
  logic [csr_pkg::XLEN-1:0] mscratch_q;

  // ----------------------------------------------------------------------
  // software configured registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtvec_q    <= csr_pkg::MTVEC_RESET;
      mie_q      <= '0; // all sources masked
      mscratch_q <= '0;
    end else begin
      if (wr_mtvec_i) begin
        mtvec_q <= csr_pkg::csr_apply(mtvec_q, op_i, wdata_i);
      end
      if (wr_mie_i) begin
        // only meie, mtie and msie exist
        mie_q <= csr_pkg::csr_apply(mie_q, op_i, wdata_i) & csr_pkg::MIE_MASK;
      end
      if (wr_mscratch_i) begin
        mscratch_q <= csr_pkg::csr_apply(mscratch_q, op_i, wdata_i);
      end
    end
  end

  assign mtvec_o    = mtvec_q;
  assign mie_o      = mie_q;
  assign mscratch_o = mscratch_q;

endmodule

// File: rtl/csr_cycle_counter.sv
`timescale 1ns/1ps

module csr_cycle_counter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [csr_pkg::XLEN-1:0] wdata_i,
  input  csr_pkg::csr_op_e         op_i,
  input  logic                     wr_cycle_lo_i,
  input  logic                     wr_cycle_hi_i,
  output logic [csr_pkg::XLEN-1:0] mcycle_o,
  output logic [csr_pkg::XLEN-1:0] mcycleh_o
);

  localparam int CNT_W = 2 * csr_pkg::XLEN;

  logic [CNT_W-1:0] cycle_q;

  // a half write takes the place of the increment on that edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycle_q <= '0;
    end else if (wr_cycle_lo_i) begin
      cycle_q[csr_pkg::XLEN-1:0] <= csr_pkg::csr_apply(mcycle_o, op_i, wdata_i);
    end else if (wr_cycle_hi_i) begin
      cycle_q[CNT_W-1:csr_pkg::XLEN] <= csr_pkg::csr_apply(mcycleh_o, op_i, wdata_i);
    end else begin
      cycle_q <= cycle_q + 1'b1; // free running
    end
  end

  assign mcycle_o  = cycle_q[csr_pkg::XLEN-1:0];
  assign mcycleh_o = cycle_q[CNT_W-1:csr_pkg::XLEN];

endmodule

// File: rtl/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux (
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic                           mstatus_mie_i,
  input  logic                           mstatus_mpie_i,
  input  logic [csr_pkg::XLEN-1:0]       mtvec_i,
  input  logic [csr_pkg::XLEN-1:0]       mepc_i,
  input  logic [csr_pkg::XLEN-1:0]       mcause_i,
  input  logic [csr_pkg::XLEN-1:0]       mtval_i,
  input  logic [csr_pkg::XLEN-1:0]       mie_i,
  input  logic [csr_pkg::XLEN-1:0]       mscratch_i,
  input  logic [csr_pkg::XLEN-1:0]       mcycle_i,
  input  logic [csr_pkg::XLEN-1:0]       mcycleh_i,
  output logic [csr_pkg::XLEN-1:0]       csr_rdata_o
);

  logic [csr_pkg::XLEN-1:0] mstatus;

  // mpp fixed at machine, all other fields zero
  always_comb begin
    mstatus        = '0;
    mstatus[12:11] = csr_pkg::MPP_MACHINE;
    mstatus[7]     = mstatus_mpie_i;
    mstatus[3]     = mstatus_mie_i;
  end

  always_comb begin
    case (csr_addr_i)
      csr_pkg::ADDR_MSTATUS:  csr_rdata_o = mstatus;
      csr_pkg::ADDR_MISA:     csr_rdata_o = csr_pkg::MISA_VALUE;
      csr_pkg::ADDR_MIE:      csr_rdata_o = mie_i;
      csr_pkg::ADDR_MTVEC:    csr_rdata_o = mtvec_i;
      csr_pkg::ADDR_MSCRATCH: csr_rdata_o = mscratch_i;
      csr_pkg::ADDR_MEPC:     csr_rdata_o = mepc_i;
      csr_pkg::ADDR_MCAUSE:   csr_rdata_o = mcause_i;
      csr_pkg::ADDR_MTVAL:    csr_rdata_o = mtval_i;
      csr_pkg::ADDR_MIP:      csr_rdata_o = '0; // no pending interrupts
      csr_pkg::ADDR_MCYCLE:   csr_rdata_o = mcycle_i;
      csr_pkg::ADDR_MCYCLEH:  csr_rdata_o = mcycleh_i;
      default:                csr_rdata_o = '0; // unimplemented csr
    endcase
  end

endmodule

// File: rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // decode stage
  input  logic [csr_pkg::XLEN-1:0]      pc_i,
  input  logic [csr_pkg::XLEN-1:0]      inst_i,
  input  logic [csr_pkg::XLEN-1:0]      rs1_i,
  input  logic [csr_pkg::ZIMM_W-1:0]    zimm_i,
  input  logic                          use_zimm_i,
  input  csr_pkg::csr_op_e              csr_op_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::excp_e                excp_i,
  // read data and fetch redirects
  output logic [csr_pkg::XLEN-1:0]      csr_rdata_o,
  output logic                          trap_tkn_o,
  output logic [csr_pkg::XLEN-1:0]      trap_vec_o,
  output logic                          mret_tkn_o,
  output logic [csr_pkg::XLEN-1:0]      mret_pc_o
);

  // ----------------------------------------------------------------------
  // write path
  // ----------------------------------------------------------------------
  logic [csr_pkg::XLEN-1:0] wdata;
  csr_pkg::csr_op_e         op;
  logic wr_mtvec, wr_mie, wr_mscratch, wr_mepc, wr_mtval;
  logic wr_cycle_lo, wr_cycle_hi;

  // register values
  logic [csr_pkg::XLEN-1:0] mepc, mcause, mtval;
  logic [csr_pkg::XLEN-1:0] mtvec, mie, mscratch;
  logic [csr_pkg::XLEN-1:0] mcycle, mcycleh;
  logic                     mstatus_mie, mstatus_mpie;

  csr_write_ctrl u_write_ctrl (
    .rs1_i         (rs1_i),
    .zimm_i        (zimm_i),
    .use_zimm_i    (use_zimm_i),
    .csr_op_i      (csr_op_i),
    .csr_addr_i    (csr_addr_i),
    .excp_i        (excp_i),
    .wdata_o       (wdata),
    .op_o          (op),
    .wr_mtvec_o    (wr_mtvec),
    .wr_mie_o      (wr_mie),
    .wr_mscratch_o (wr_mscratch),
    .wr_mepc_o     (wr_mepc),
    .wr_mtval_o    (wr_mtval),
    .wr_cycle_lo_o (wr_cycle_lo),
    .wr_cycle_hi_o (wr_cycle_hi)
  );

  // ----------------------------------------------------------------------
  // register blocks
  // ----------------------------------------------------------------------
  csr_trap_unit u_trap_unit (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .pc_i           (pc_i),
    .inst_i         (inst_i),
    .excp_i         (excp_i),
    .wdata_i        (wdata),
    .op_i           (op),
    .wr_mepc_i      (wr_mepc),
    .wr_mtval_i     (wr_mtval),
    .mtvec_i        (mtvec),
    .mepc_o         (mepc),
    .mcause_o       (mcause),
    .mtval_o        (mtval),
    .mstatus_mie_o  (mstatus_mie),
    .mstatus_mpie_o (mstatus_mpie),
    .trap_tkn_o     (trap_tkn_o),
    .trap_vec_o     (trap_vec_o),
    .mret_tkn_o     (mret_tkn_o),
    .mret_pc_o      (mret_pc_o)
  );

  csr_setup_regs u_setup_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wdata_i       (wdata),
    .op_i          (op),
    .wr_mtvec_i    (wr_mtvec),
    .wr_mie_i      (wr_mie),
    .wr_mscratch_i (wr_mscratch),
    .mtvec_o       (mtvec),
    .mie_o         (mie),
    .mscratch_o    (mscratch)
  );

  csr_cycle_counter u_cycle_counter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wdata_i       (wdata),
    .op_i          (op),
    .wr_cycle_lo_i (wr_cycle_lo),
    .wr_cycle_hi_i (wr_cycle_hi),
    .mcycle_o      (mcycle),
    .mcycleh_o     (mcycleh)
  );

  csr_read_mux u_read_mux (
    .csr_addr_i     (csr_addr_i),
    .mstatus_mie_i  (mstatus_mie),
    .mstatus_mpie_i (mstatus_mpie),
    .mtvec_i        (mtvec),
    .mepc_i         (mepc),
    .mcause_i       (mcause),
    .mtval_i        (mtval),
    .mie_i          (mie),
    .mscratch_i     (mscratch),
    .mcycle_i       (mcycle),
    .mcycleh_i      (mcycleh),
    .csr_rdata_o    (csr_rdata_o)
  );

endmodule

// File: tests/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYC  = 10;
  // cycle budget per test, sums to the watchdog limit
  localparam int T_RESET = 8;
  localparam int T_RMW   = 60;
  localparam int T_MIE   = 6;
  localparam int T_EXCP  = 18;
  localparam int T_MRET  = 4;
  localparam int T_CYCLE = 28;
  localparam int MARGIN  = 50;
  localparam int WATCHDOG_NS =
    (RESET_CYC + T_RESET + T_RMW + T_MIE + T_EXCP + T_MRET + T_CYCLE + MARGIN) * CLK_PERIOD;

  logic clk_i, rst_n_i, use_zimm_i;
  logic [31:0] pc_i, inst_i, rs1_i, csr_rdata_o, trap_vec_o, mret_pc_o;
  logic [4:0] zimm_i;
  logic [11:0] csr_addr_i;
  csr_pkg::csr_op_e csr_op_i;
  csr_pkg::excp_e excp_i;
  logic trap_tkn_o, mret_tkn_o;

  integer seed = 32'h2712;
  int fail_cnt = 0;
  int tests_run = 0;
  int tests_ok = 0;
  int test_start;
  logic [31:0] pc_v, inst_v, trap_pc, c0, c1, hi_v;
  csr_pkg::excp_e kinds [3];
  int n;

  // reference model state
  logic [31:0] m_mtvec, m_mie, m_mscratch, m_mepc, m_mcause, m_mtval;
  logic m_mie_bit, m_mpie_bit;
  logic [63:0] m_cycle;

  csr_unit dut0 (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pc_i(pc_i), .inst_i(inst_i), .rs1_i(rs1_i),
    .zimm_i(zimm_i), .use_zimm_i(use_zimm_i), .csr_op_i(csr_op_i),
    .csr_addr_i(csr_addr_i), .excp_i(excp_i), .csr_rdata_o(csr_rdata_o),
    .trap_tkn_o(trap_tkn_o), .trap_vec_o(trap_vec_o),
    .mret_tkn_o(mret_tkn_o), .mret_pc_o(mret_pc_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // checks and reference model
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      fail_cnt++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      fail_cnt++;
      $display("error at %0t: %s did not hold", $time, what);
    end
  endtask

  function automatic logic [31:0] expect_rmw(input logic [31:0] old_v,
                                             input csr_pkg::csr_op_e op,
                                             input logic [31:0] wd);
    case (op)
      csr_pkg::CSR_RW: return wd;
      csr_pkg::CSR_RS: return old_v | wd;
      csr_pkg::CSR_RC: return old_v & ~wd;
      default:         return old_v;
    endcase
  endfunction

  function automatic logic [31:0] cause_code(input csr_pkg::excp_e ex);
    case (ex)
      csr_pkg::EXCP_ILLEGAL: return 32'd2;
      csr_pkg::EXCP_BREAK:   return 32'd3;
      default:               return 32'd8; // ecall from u-mode
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      csr_pkg::ADDR_MSTATUS: begin
        v[12:11] = csr_pkg::MPP_MACHINE;
        v[7]     = m_mpie_bit;
        v[3]     = m_mie_bit;
      end
      csr_pkg::ADDR_MISA:     v = csr_pkg::MISA_VALUE;
      csr_pkg::ADDR_MIE:      v = m_mie;
      csr_pkg::ADDR_MTVEC:    v = m_mtvec;
      csr_pkg::ADDR_MSCRATCH: v = m_mscratch;
      csr_pkg::ADDR_MEPC:     v = m_mepc;
      csr_pkg::ADDR_MCAUSE:   v = m_mcause;
      csr_pkg::ADDR_MTVAL:    v = m_mtval;
      csr_pkg::ADDR_MCYCLE:   v = m_cycle[31:0];
      csr_pkg::ADDR_MCYCLEH:  v = m_cycle[63:32];
      default:                v = '0; // mip and unknown
    endcase
    return v;
  endfunction

  task automatic model_step();
    logic [31:0] wd;
    logic trap, mret, wen;
    wd   = use_zimm_i ? {27'b0, zimm_i} : rs1_i;
    trap = excp_i inside {csr_pkg::EXCP_ILLEGAL, csr_pkg::EXCP_ECALL_U, csr_pkg::EXCP_BREAK};
    mret = (excp_i == csr_pkg::EXCP_MRET);
    wen  = (csr_op_i != csr_pkg::CSR_NONE) && (excp_i == csr_pkg::EXCP_NONE);
    if (trap) begin
      m_mepc   = pc_i;
      m_mcause = cause_code(excp_i);
      if (excp_i == csr_pkg::EXCP_ILLEGAL) m_mtval = inst_i;
    end else if (mret) begin
      m_mie_bit  = m_mpie_bit;
      m_mpie_bit = 1'b1;
    end else if (wen) begin
      case (csr_addr_i)
        csr_pkg::ADDR_MTVEC:    m_mtvec = expect_rmw(m_mtvec, csr_op_i, wd);
        csr_pkg::ADDR_MIE:      m_mie = expect_rmw(m_mie, csr_op_i, wd) & csr_pkg::MIE_MASK;
        csr_pkg::ADDR_MSCRATCH: m_mscratch = expect_rmw(m_mscratch, csr_op_i, wd);
        csr_pkg::ADDR_MEPC:     m_mepc = expect_rmw(m_mepc, csr_op_i, wd);
        csr_pkg::ADDR_MTVAL:    m_mtval = expect_rmw(m_mtval, csr_op_i, wd);
        default: ;
      endcase
    end
    // a half write takes the place of the increment
    if (wen && csr_addr_i == csr_pkg::ADDR_MCYCLE)
      m_cycle[31:0] = expect_rmw(m_cycle[31:0], csr_op_i, wd);
    else if (wen && csr_addr_i == csr_pkg::ADDR_MCYCLEH)
      m_cycle[63:32] = expect_rmw(m_cycle[63:32], csr_op_i, wd);
    else
      m_cycle = m_cycle + 64'd1;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      m_mtvec = csr_pkg::MTVEC_RESET;
      {m_mie, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
      m_mie_bit = 1'b0;
      m_mpie_bit = 1'b1;
      m_cycle = '0;
    end else begin
      check_value("csr_rdata_o", model_read(csr_addr_i), csr_rdata_o);
      check_value("trap_tkn_o", (excp_i inside {csr_pkg::EXCP_ILLEGAL, csr_pkg::EXCP_ECALL_U,
                  csr_pkg::EXCP_BREAK}), trap_tkn_o);
      check_value("trap_vec_o", m_mtvec, trap_vec_o);
      check_value("mret_tkn_o", excp_i == csr_pkg::EXCP_MRET, mret_tkn_o);
      check_value("mret_pc_o", m_mepc, mret_pc_o);
      model_step();
    end
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  task automatic issue(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                       input logic [31:0] rs1, input logic [4:0] zimm,
                       input logic use_z, input csr_pkg::excp_e ex);
    pc_v   = $random(seed) & 32'hFFFF_FFFC;
    inst_v = $random(seed);
    @(posedge clk_i);
    pc_i <= pc_v;
    inst_i <= inst_v;
    rs1_i <= rs1;
    zimm_i <= zimm;
    use_zimm_i <= use_z;
    csr_op_i <= op;
    csr_addr_i <= addr;
    excp_i <= ex;
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp);
    issue(csr_pkg::CSR_NONE, addr, '0, '0, 1'b0, csr_pkg::EXCP_NONE);
    @(negedge clk_i);
    check_value("csr_rdata_o", exp, csr_rdata_o);
  endtask

  function automatic csr_pkg::csr_op_e pick_op();
    case ($unsigned($random(seed)) % 3)
      0:       return csr_pkg::CSR_RW;
      1:       return csr_pkg::CSR_RS;
      default: return csr_pkg::CSR_RC;
    endcase
  endfunction

  function automatic logic [11:0] pick_addr();
    case ($unsigned($random(seed)) % 4)
      0:       return csr_pkg::ADDR_MSCRATCH;
      1:       return csr_pkg::ADDR_MTVEC;
      2:       return csr_pkg::ADDR_MEPC;
      default: return csr_pkg::ADDR_MTVAL;
    endcase
  endfunction

  task automatic finish_test(input string name);
    tests_run++;
    if (fail_cnt == test_start) tests_ok++;
    $display("test %-10s %s (%0d errors)", name, (fail_cnt == test_start) ? "ok" : "FAILED",
             fail_cnt - test_start);
    test_start = fail_cnt;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [11:0] a;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    {pc_i, inst_i, rs1_i, zimm_i, use_zimm_i, csr_addr_i} = '0;
    csr_op_i = csr_pkg::CSR_NONE;
    excp_i = csr_pkg::EXCP_NONE;
    repeat (RESET_CYC) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_start = 0;

    read_check(csr_pkg::ADDR_MSTATUS, 32'h0000_1880);
    read_check(csr_pkg::ADDR_MISA, csr_pkg::MISA_VALUE);
    read_check(csr_pkg::ADDR_MTVEC, csr_pkg::MTVEC_RESET);
    read_check(csr_pkg::ADDR_MIP, 32'h0);
    read_check(csr_pkg::ADDR_MSCRATCH, 32'h0);
    finish_test("reset");

    repeat (24) begin
      a = pick_addr();
      issue(pick_op(), a, $random(seed), $random(seed), $random(seed), csr_pkg::EXCP_NONE);
      issue(csr_pkg::CSR_NONE, a, '0, '0, 1'b0, csr_pkg::EXCP_NONE); // model compares read
    end
    issue(csr_pkg::CSR_RW, csr_pkg::ADDR_MISA, $random(seed), '0, 1'b0, csr_pkg::EXCP_NONE);
    read_check(csr_pkg::ADDR_MISA, csr_pkg::MISA_VALUE);
    issue(csr_pkg::CSR_RW, csr_pkg::ADDR_MCAUSE, $random(seed), '0, 1'b0, csr_pkg::EXCP_NONE);
    read_check(csr_pkg::ADDR_MCAUSE, 32'h0);
    finish_test("rmw");

    issue(csr_pkg::CSR_RW, csr_pkg::ADDR_MIE, 32'hFFFF_FFFF, '0, 1'b0, csr_pkg::EXCP_NONE);
    read_check(csr_pkg::ADDR_MIE, 32'h0000_0888);
    issue(csr_pkg::CSR_RC, csr_pkg::ADDR_MIE, 32'h0000_0800, '0, 1'b0, csr_pkg::EXCP_NONE);
    read_check(csr_pkg::ADDR_MIE, 32'h0000_0088);
    finish_test("mie_mask");

    kinds[0] = csr_pkg::EXCP_ILLEGAL;
    kinds[1] = csr_pkg::EXCP_ECALL_U;
    kinds[2] = csr_pkg::EXCP_BREAK;
    foreach (kinds[k]) begin
      // csr write in the same cycle must be dropped
      issue(csr_pkg::CSR_RW, csr_pkg::ADDR_MSCRATCH, $random(seed), '0, 1'b0, kinds[k]);
      trap_pc = pc_v;
      @(negedge clk_i);
      check_flag("trap_tkn_o high with exception", trap_tkn_o);
      read_check(csr_pkg::ADDR_MEPC, trap_pc);
      read_check(csr_pkg::ADDR_MCAUSE, cause_code(kinds[k]));
      issue(csr_pkg::CSR_NONE, csr_pkg::ADDR_MTVAL, '0, '0, 1'b0, csr_pkg::EXCP_NONE);
      issue(csr_pkg::CSR_NONE, csr_pkg::ADDR_MSCRATCH, '0, '0, 1'b0, csr_pkg::EXCP_NONE);
    end
    finish_test("exceptions");

    issue(csr_pkg::CSR_NONE, csr_pkg::ADDR_MSTATUS, '0, '0, 1'b0, csr_pkg::EXCP_MRET);
    @(negedge clk_i);
    check_flag("mret_tkn_o high on mret", mret_tkn_o);
    read_check(csr_pkg::ADDR_MSTATUS, 32'h0000_1888);
    finish_test("mret");

    n = 3 + ($unsigned($random(seed)) % 16);
    issue(csr_pkg::CSR_NONE, csr_pkg::ADDR_MCYCLE, '0, '0, 1'b0, csr_pkg::EXCP_NONE);
    @(negedge clk_i);
    c0 = csr_rdata_o;
    repeat (n) issue(csr_pkg::CSR_NONE, csr_pkg::ADDR_MCYCLE, '0, '0, 1'b0, csr_pkg::EXCP_NONE);
    @(negedge clk_i);
    c1 = csr_rdata_o;
    check_value("mcycle delta", n, c1 - c0);
    hi_v = $random(seed);
    issue(csr_pkg::CSR_RW, csr_pkg::ADDR_MCYCLEH, hi_v, '0, 1'b0, csr_pkg::EXCP_NONE);
    read_check(csr_pkg::ADDR_MCYCLEH, hi_v);
    issue(csr_pkg::CSR_NONE, csr_pkg::ADDR_MCYCLE, '0, '0, 1'b0, csr_pkg::EXCP_NONE);
    @(negedge clk_i);
    check_flag("mcycle low half kept counting", csr_rdata_o > c1);
    issue(csr_pkg::CSR_RW, csr_pkg::ADDR_MCYCLE, $random(seed), '0, 1'b0, csr_pkg::EXCP_NONE);
    issue(csr_pkg::CSR_NONE, csr_pkg::ADDR_MCYCLE, '0, '0, 1'b0, csr_pkg::EXCP_NONE);
    @(negedge clk_i); // model compares read
    finish_test("cycle");

    $display("%0d of %0d tests ok, %0d checks failed", tests_ok, tests_run, fail_cnt);
    if (fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: list.f
common/csr_pkg.sv
rtl/csr_write_ctrl.sv
rtl/csr_trap_unit.sv
rtl/csr_setup_regs.sv
rtl/csr_cycle_counter.sv
rtl/csr_read_mux.sv
rtl/csr_unit.sv
tests/csr_unit_tb.sv
